/* sigma_tile_cfg.svh */
`ifndef SIGMA_TILE_CFG_SVH
`define SIGMA_TILE_CFG_SVH

// bus widths
`define SIGMA_DATA_W        32
`define SIGMA_ADDR_W        32

// ram geometry, word index starts at address bit 2
`define SIGMA_MEM_WORDS     1024
`define SIGMA_MEM_AW        10

// address bit that moves a request from ram to the sfr block
`define SIGMA_SEL_BIT       16

// value answered by the id register
`define SIGMA_CORENUM       5

// sfr register indices
`define SIGMA_SFR_ID        0
`define SIGMA_SFR_SCRATCH   1

`endif

/* sigma_tile_pkg.sv */
`default_nettype none

`include "sigma_tile_cfg.svh"

package sigma_tile_pkg;

    localparam int SFR_IDX_W = `SIGMA_SEL_BIT - 2;
    localparam int BE_W      = `SIGMA_DATA_W / 8;

    // ram view: bits between the word index and the select bit alias
    typedef struct packed {
        logic [`SIGMA_ADDR_W-`SIGMA_SEL_BIT-2:0]  upper;
        logic                                     sel;
        logic [`SIGMA_SEL_BIT-`SIGMA_MEM_AW-3:0]  alias_bits;
        logic [`SIGMA_MEM_AW-1:0]                 idx;
        logic [1:0]                               offset;
    } ram_addr_t;

    typedef struct packed {
        logic [`SIGMA_ADDR_W-`SIGMA_SEL_BIT-2:0]  upper;
        logic                                     sel;
        logic [SFR_IDX_W-1:0]                     idx;
        logic [1:0]                               offset;
    } sfr_addr_t;

    // one address word, read either way depending on the target
    typedef union packed {
        ram_addr_t ram;
        sfr_addr_t sfr;
    } mem_addr_u;

    typedef struct packed {
        logic                       we;
        mem_addr_u                  addr;
        logic [BE_W-1:0]            be;
        logic [`SIGMA_DATA_W-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic                       resp;
        logic [`SIGMA_DATA_W-1:0]   rdata;
    } mem_resp_t;

    typedef enum logic {MST_CPU = 1'b0, MST_HPI = 1'b1} master_e;
    typedef enum logic {TGT_RAM = 1'b0, TGT_SFR = 1'b1} target_e;

endpackage

`default_nettype wire

/* bus_arbiter.sv */
`default_nettype none

module bus_arbiter
(
    input  logic                        clk_i
    , input  logic                      rst_n_i

    , input  logic                      cpu_req_i
    , input  sigma_tile_pkg::mem_req_t  cpu_bus_i
    , output logic                      cpu_ack_o

    , input  logic                      hpi_req_i
    , input  sigma_tile_pkg::mem_req_t  hpi_bus_i
    , output logic                      hpi_ack_o

    , output logic                      req_o
    , output sigma_tile_pkg::mem_req_t  bus_o
    , output sigma_tile_pkg::master_e   src_o
);

    import sigma_tile_pkg::*;

    // winner of the most recent contested cycle
    master_e last_q;
    master_e winner;
    logic    contested;

    assign contested = cpu_req_i & hpi_req_i;

    always_comb
    begin
        if (contested)
        begin
            // the loser of the last contest goes first
            winner = (last_q == MST_CPU) ? MST_HPI : MST_CPU;
        end
        else if (hpi_req_i)
        begin
            winner = MST_HPI;
        end
        else
        begin
            winner = MST_CPU;
        end
    end

    // reset value lets the cpu win the first contest
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            last_q <= MST_HPI;
        end
        else if (contested)
        begin
            last_q <= winner;
        end
    end

    assign cpu_ack_o = cpu_req_i & (winner == MST_CPU);
    assign hpi_ack_o = hpi_req_i & (winner == MST_HPI);

    assign req_o = cpu_req_i | hpi_req_i;
    assign bus_o = (winner == MST_HPI) ? hpi_bus_i : cpu_bus_i;
    assign src_o = winner;

endmodule

`default_nettype wire

/* addr_decode.sv */
`default_nettype none

module addr_decode
(
    input  logic                        req_i
    , input  sigma_tile_pkg::mem_req_t  bus_i

    , output logic                      ram_req_o
    , output sigma_tile_pkg::mem_req_t  ram_bus_o

    , output logic                      sfr_req_o
    , output sigma_tile_pkg::mem_req_t  sfr_bus_o

    , output sigma_tile_pkg::target_e   tgt_o
);

    import sigma_tile_pkg::*;

    target_e tgt;

    // select bit sits at the same place in both address views
    assign tgt = bus_i.addr.ram.sel ? TGT_SFR : TGT_RAM;

    always_comb
    begin
        ram_req_o = 1'b0;
        sfr_req_o = 1'b0;
        ram_bus_o = '0;
        sfr_bus_o = '0;

        if (tgt == TGT_SFR)
        begin
            sfr_req_o = req_i;
            sfr_bus_o = bus_i;
        end
        else
        begin
            ram_req_o = req_i;
            ram_bus_o = bus_i;
        end
    end

    assign tgt_o = tgt;

endmodule

`default_nettype wire

/* ram_bank.sv */
`default_nettype none

`include "sigma_tile_cfg.svh"

module ram_bank
(
    input  logic                        clk_i

    , input  logic                      req_i
    , input  sigma_tile_pkg::mem_req_t  bus_i

    , output logic [`SIGMA_DATA_W-1:0]  rdata_o
);

    import sigma_tile_pkg::*;

    logic [`SIGMA_DATA_W-1:0] mem [`SIGMA_MEM_WORDS];
    logic [`SIGMA_MEM_AW-1:0] idx;

    // upper address bits are ignored, so they alias
    assign idx = bus_i.addr.ram.idx;

    always_ff @(posedge clk_i)
    begin
        if (req_i && bus_i.we)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (bus_i.be[b])
                begin
                    mem[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // read data valid the cycle after acceptance
    always_ff @(posedge clk_i)
    begin
        if (req_i && !bus_i.we)
        begin
            rdata_o <= mem[idx];
        end
    end

endmodule

`default_nettype wire

/* sfr_bank.sv */
`default_nettype none

`include "sigma_tile_cfg.svh"

module sfr_bank
(
    input  logic                        clk_i
    , input  logic                      rst_n_i

    , input  logic                      req_i
    , input  sigma_tile_pkg::mem_req_t  bus_i

    , output logic [`SIGMA_DATA_W-1:0]  rdata_o
);

    import sigma_tile_pkg::*;

    localparam logic [SFR_IDX_W-1:0] IDX_ID      = SFR_IDX_W'(`SIGMA_SFR_ID);
    localparam logic [SFR_IDX_W-1:0] IDX_SCRATCH = SFR_IDX_W'(`SIGMA_SFR_SCRATCH);

    logic [`SIGMA_DATA_W-1:0] scratch_q;
    logic [`SIGMA_DATA_W-1:0] rd_mux;
    logic [SFR_IDX_W-1:0]     idx;

    assign idx = bus_i.addr.sfr.idx;

    // only scratch is writable
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            scratch_q <= '0;
        end
        else if (req_i && bus_i.we && (idx == IDX_SCRATCH))
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (bus_i.be[b])
                begin
                    scratch_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb
    begin
        case (idx)
            IDX_ID:      rd_mux = `SIGMA_DATA_W'(`SIGMA_CORENUM);
            IDX_SCRATCH: rd_mux = scratch_q;
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (req_i && !bus_i.we)
        begin
            rdata_o <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* resp_router.sv */
`default_nettype none

`include "sigma_tile_cfg.svh"

module resp_router
(
    input  logic                         clk_i
    , input  logic                       rst_n_i

    , input  logic                       req_i
    , input  logic                       we_i
    , input  sigma_tile_pkg::master_e    src_i
    , input  sigma_tile_pkg::target_e    tgt_i

    , input  logic [`SIGMA_DATA_W-1:0]   ram_rdata_i
    , input  logic [`SIGMA_DATA_W-1:0]   sfr_rdata_i

    , output sigma_tile_pkg::mem_resp_t  cpu_resp_o
    , output sigma_tile_pkg::mem_resp_t  hpi_resp_o
);

    import sigma_tile_pkg::*;

    logic                     pend_q;
    master_e                  src_q;
    target_e                  tgt_q;
    logic [`SIGMA_DATA_W-1:0] rdata;

    // one read in flight per cycle, so a single slot is enough
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            pend_q <= 1'b0;
            src_q  <= MST_CPU;
            tgt_q  <= TGT_RAM;
        end
        else
        begin
            pend_q <= req_i & ~we_i;
            src_q  <= src_i;
            tgt_q  <= tgt_i;
        end
    end

    assign rdata = (tgt_q == TGT_SFR) ? sfr_rdata_i : ram_rdata_i;

    assign cpu_resp_o.resp  = pend_q & (src_q == MST_CPU);
    assign cpu_resp_o.rdata = rdata;
    assign hpi_resp_o.resp  = pend_q & (src_q == MST_HPI);
    assign hpi_resp_o.rdata = rdata;

endmodule

`default_nettype wire

/* sigma_tile.sv */
`default_nettype none

`include "sigma_tile_cfg.svh"

module sigma_tile
(
    input  logic                         clk_i
    , input  logic                       rst_n_i

    // processor data port
    , input  logic                       cpu_req_i
    , input  sigma_tile_pkg::mem_req_t   cpu_bus_i
    , output logic                       cpu_ack_o
    , output sigma_tile_pkg::mem_resp_t  cpu_resp_o

    // host port
    , input  logic                       hpi_req_i
    , input  sigma_tile_pkg::mem_req_t   hpi_bus_i
    , output logic                       hpi_ack_o
    , output sigma_tile_pkg::mem_resp_t  hpi_resp_o
);

    import sigma_tile_pkg::*;

    logic                     arb_req;
    mem_req_t                 arb_bus;
    master_e                  arb_src;

    logic                     ram_req;
    mem_req_t                 ram_bus;
    logic                     sfr_req;
    mem_req_t                 sfr_bus;
    target_e                  dec_tgt;

    logic [`SIGMA_DATA_W-1:0] ram_rdata;
    logic [`SIGMA_DATA_W-1:0] sfr_rdata;

    bus_arbiter i_arb
    (
        .clk_i        (clk_i)
        , .rst_n_i    (rst_n_i)
        , .cpu_req_i  (cpu_req_i)
        , .cpu_bus_i  (cpu_bus_i)
        , .cpu_ack_o  (cpu_ack_o)
        , .hpi_req_i  (hpi_req_i)
        , .hpi_bus_i  (hpi_bus_i)
        , .hpi_ack_o  (hpi_ack_o)
        , .req_o      (arb_req)
        , .bus_o      (arb_bus)
        , .src_o      (arb_src)
    );

    addr_decode i_dec
    (
        .req_i        (arb_req)
        , .bus_i      (arb_bus)
        , .ram_req_o  (ram_req)
        , .ram_bus_o  (ram_bus)
        , .sfr_req_o  (sfr_req)
        , .sfr_bus_o  (sfr_bus)
        , .tgt_o      (dec_tgt)
    );

    ram_bank i_ram
    (
        .clk_i        (clk_i)
        , .req_i      (ram_req)
        , .bus_i      (ram_bus)
        , .rdata_o    (ram_rdata)
    );

    sfr_bank i_sfr
    (
        .clk_i        (clk_i)
        , .rst_n_i    (rst_n_i)
        , .req_i      (sfr_req)
        , .bus_i      (sfr_bus)
        , .rdata_o    (sfr_rdata)
    );

    resp_router i_resp
    (
        .clk_i          (clk_i)
        , .rst_n_i      (rst_n_i)
        , .req_i        (arb_req)
        , .we_i         (arb_bus.we)
        , .src_i        (arb_src)
        , .tgt_i        (dec_tgt)
        , .ram_rdata_i  (ram_rdata)
        , .sfr_rdata_i  (sfr_rdata)
        , .cpu_resp_o   (cpu_resp_o)
        , .hpi_resp_o   (hpi_resp_o)
    );

endmodule

`default_nettype wire

/* sigma_tile_props.sv */
`default_nettype none

module sigma_tile_props
(
    input  logic                         clk_i
    , input  logic                       rst_n_i
    , input  logic                       cpu_req_i
    , input  logic                       cpu_ack_i
    , input  sigma_tile_pkg::mem_req_t   cpu_bus_i
    , input  sigma_tile_pkg::mem_resp_t  cpu_resp_i
    , input  logic                       hpi_req_i
    , input  logic                       hpi_ack_i
    , input  sigma_tile_pkg::mem_req_t   hpi_bus_i
    , input  sigma_tile_pkg::mem_resp_t  hpi_resp_i
);

    ack_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!cpu_ack_i || cpu_req_i) && (!hpi_ack_i || hpi_req_i))
        else $error("ack given without a request");

    single_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(cpu_ack_i && hpi_ack_i))
        else $error("both masters acked in the same cycle");

    // read data comes back one cycle after acceptance
    cpu_read_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cpu_ack_i && !cpu_bus_i.we |=> cpu_resp_i.resp)
        else $error("cpu read not answered one cycle after ack");

    hpi_read_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hpi_ack_i && !hpi_bus_i.we |=> hpi_resp_i.resp)
        else $error("hpi read not answered one cycle after ack");

    cpu_resp_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cpu_resp_i.resp |-> $past(cpu_ack_i && !cpu_bus_i.we))
        else $error("cpu response without an accepted read");

    hpi_resp_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hpi_resp_i.resp |-> $past(hpi_ack_i && !hpi_bus_i.we))
        else $error("hpi response without an accepted read");

endmodule

bind sigma_tile sigma_tile_props i_props
(
    .clk_i        (clk_i)
    , .rst_n_i    (rst_n_i)
    , .cpu_req_i  (cpu_req_i)
    , .cpu_ack_i  (cpu_ack_o)
    , .cpu_bus_i  (cpu_bus_i)
    , .cpu_resp_i (cpu_resp_o)
    , .hpi_req_i  (hpi_req_i)
    , .hpi_ack_i  (hpi_ack_o)
    , .hpi_bus_i  (hpi_bus_i)
    , .hpi_resp_i (hpi_resp_o)
);

`default_nettype wire

/* sigma_tile_tb.sv */
`default_nettype none

`include "sigma_tile_cfg.svh"

module sigma_tile_tb;

    import sigma_tile_pkg::*;

    localparam int INIT_WORDS  = 8;
    localparam int STREAM_OPS  = 60;
    localparam int CYCLE_LIMIT = (INIT_WORDS + 2 * STREAM_OPS) * 4 + 100;

    typedef struct packed {
        logic [`SIGMA_DATA_W-1:0] data;
        logic [31:0]              cycle;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cpu_req;
    logic        hpi_req;
    mem_req_t    cpu_bus;
    mem_req_t    hpi_bus;
    logic        cpu_ack;
    logic        hpi_ack;
    mem_resp_t   cpu_resp;
    mem_resp_t   hpi_resp;

    logic [`SIGMA_DATA_W-1:0] ram_model [`SIGMA_MEM_WORDS];
    logic [`SIGMA_DATA_W-1:0] scratch_model;
    expect_t     cpu_exp [$];
    expect_t     hpi_exp [$];
    // master that takes the next contested cycle
    master_e     contest_next;
    logic [31:0] lfsr [2];
    logic [31:0] cycle_cnt = '0;
    int          data_errs = 0;
    int          proto_errs = 0;

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    sigma_tile i_dut
    (
        .clk_i        (clk)
        , .rst_n_i    (rst_n)
        , .cpu_req_i  (cpu_req)
        , .cpu_bus_i  (cpu_bus)
        , .cpu_ack_o  (cpu_ack)
        , .cpu_resp_o (cpu_resp)
        , .hpi_req_i  (hpi_req)
        , .hpi_bus_i  (hpi_bus)
        , .hpi_ack_o  (hpi_ack)
        , .hpi_resp_o (hpi_resp)
    );

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic draw(input master_e m, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr[m] = lfsr_step(lfsr[m]);
            v = {v[30:0], lfsr[m][0]};
        end
    endtask

    function automatic logic [`SIGMA_DATA_W-1:0] merge_bytes(
        input logic [`SIGMA_DATA_W-1:0] old,
        input logic [`SIGMA_DATA_W-1:0] wdata,
        input logic [BE_W-1:0]          be);
        logic [`SIGMA_DATA_W-1:0] r;
        r = old;
        for (int b = 0; b < BE_W; b++)
        begin
            if (be[b])
                r[8*b +: 8] = wdata[8*b +: 8];
        end
        return r;
    endfunction

    // expected read value from the model and the fixed sfr rules
    function automatic logic [`SIGMA_DATA_W-1:0] expected_read(input mem_addr_u a);
        if (!a.ram.sel)
            return ram_model[a.ram.idx];
        if (a.sfr.idx == SFR_IDX_W'(`SIGMA_SFR_ID))
            return `SIGMA_DATA_W'(`SIGMA_CORENUM);
        if (a.sfr.idx == SFR_IDX_W'(`SIGMA_SFR_SCRATCH))
            return scratch_model;
        return '0;
    endfunction

    task automatic note_accept(input master_e m, input mem_req_t r);
        expect_t e;
        e.data  = expected_read(r.addr);
        e.cycle = cycle_cnt;
        if (r.we && !r.addr.ram.sel)
            ram_model[r.addr.ram.idx] = merge_bytes(ram_model[r.addr.ram.idx], r.wdata, r.be);
        else if (r.we && r.addr.sfr.idx == SFR_IDX_W'(`SIGMA_SFR_SCRATCH))
            scratch_model = merge_bytes(scratch_model, r.wdata, r.be);
        else if (!r.we && m == MST_CPU)
            cpu_exp.push_back(e);
        else if (!r.we)
            hpi_exp.push_back(e);
    endtask

    // a lone request is granted and a contest goes to the loser of the last one
    task automatic verify_grant();
        logic exp_cpu;
        logic exp_hpi;
        exp_cpu = cpu_req && (!hpi_req || contest_next == MST_CPU);
        exp_hpi = hpi_req && (!cpu_req || contest_next == MST_HPI);
        assert (cpu_ack === exp_cpu && hpi_ack === exp_hpi) else
        begin
            proto_errs++;
            $display("ERR %0t: acks cpu %0b hpi %0b, expected cpu %0b hpi %0b",
                     $time, cpu_ack, hpi_ack, exp_cpu, exp_hpi);
        end
        if (cpu_req && hpi_req)
            contest_next = (contest_next == MST_CPU) ? MST_HPI : MST_CPU;
    endtask

    // a response is due exactly one cycle after the read was acked
    task automatic check_resp(input master_e m, input mem_resp_t r);
        expect_t e;
        int      depth;
        logic    due;
        e = '0;
        depth = (m == MST_CPU) ? cpu_exp.size() : hpi_exp.size();
        if (depth > 0)
            e = (m == MST_CPU) ? cpu_exp[0] : hpi_exp[0];
        due = (depth > 0) && (e.cycle + 1 == cycle_cnt);
        assert (r.resp == due) else
        begin
            proto_errs++;
            $display("%s port: response pulse was %0b but %0b was due at time %0t",
                     m.name(), r.resp, due, $time);
        end
        if (due)
        begin
            if (m == MST_CPU)
                void'(cpu_exp.pop_front());
            else
                void'(hpi_exp.pop_front());
            assert (!r.resp || r.rdata === e.data) else
            begin
                data_errs++;
                $display("ERR %0t: %s read returned %h, expected %h",
                         $time, m.name(), r.rdata, e.data);
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (rst_n && cpu_ack)
            note_accept(MST_CPU, cpu_bus);
        if (rst_n && hpi_ack)
            note_accept(MST_HPI, hpi_bus);
    end

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            verify_grant();
            check_resp(MST_CPU, cpu_resp);
            check_resp(MST_HPI, hpi_resp);
        end
    end

    // hold the request until the arbiter grants it
    task automatic issue(input master_e m, input mem_req_t r);
        logic acked;
        if (m == MST_CPU)
        begin
            cpu_req = 1'b1;
            cpu_bus = r;
        end
        else
        begin
            hpi_req = 1'b1;
            hpi_bus = r;
        end
        do
        begin
            @(negedge clk);
            acked = (m == MST_CPU) ? cpu_ack : hpi_ack;
            @(posedge clk);
            #1;
        end
        while (!acked);
        if (m == MST_CPU)
            cpu_req = 1'b0;
        else
            hpi_req = 1'b0;
    endtask

    task automatic run_stream(input master_e m);
        mem_req_t    r;
        logic [31:0] v;
        for (int n = 0; n < STREAM_OPS; n++)
        begin
            draw(m, 1, v);
            if (v[0])
            begin
                @(posedge clk);
                #1;
            end
            r = '0;
            draw(m, 1, v);
            r.we = v[0];
            draw(m, 2, v);
            // a quarter of the accesses go to the sfr block
            if (v[1:0] == 2'b00)
            begin
                r.addr.sfr.sel = 1'b1;
                draw(m, 2, v);
                r.addr.sfr.idx = SFR_IDX_W'(v[1:0]);
            end
            else
            begin
                draw(m, 3, v);
                r.addr.ram.idx = `SIGMA_MEM_AW'(v[2:0]);
                // alias bits must not change the word hit
                draw(m, 4, v);
                r.addr.ram.alias_bits = v[3:0];
            end
            draw(m, BE_W, v);
            r.be = v[BE_W-1:0];
            draw(m, `SIGMA_DATA_W, v);
            r.wdata = v;
            issue(m, r);
        end
    endtask

    initial
    begin
        while (cycle_cnt < CYCLE_LIMIT)
            @(posedge clk);
        $display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        mem_req_t    r;
        logic [31:0] v;
        cpu_req = 1'b0;
        hpi_req = 1'b0;
        cpu_bus = '0;
        hpi_bus = '0;
        rst_n = 1'b0;
        scratch_model = '0;
        // cpu takes the first contest after reset
        contest_next = MST_CPU;
        lfsr[MST_CPU] = 32'd66909;
        lfsr[MST_HPI] = 32'd66909;
        // move the host stream away from the cpu stream
        repeat (97) lfsr[MST_HPI] = lfsr_step(lfsr[MST_HPI]);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // every word of the test pool gets a defined value first
        for (int i = 0; i < INIT_WORDS; i++)
        begin
            r = '0;
            r.we = 1'b1;
            r.addr.ram.idx = `SIGMA_MEM_AW'(i);
            r.be = '1;
            draw(MST_CPU, `SIGMA_DATA_W, v);
            r.wdata = v;
            issue(MST_CPU, r);
        end
        fork
            run_stream(MST_CPU);
            run_stream(MST_HPI);
        join
        repeat (3) @(posedge clk);
        $display("errors: %0d data, %0d protocol", data_errs, proto_errs);
        if (data_errs + proto_errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sigma_tile.f */
+incdir+.
sigma_tile_pkg.sv
bus_arbiter.sv
addr_decode.sv
ram_bank.sv
sfr_bank.sv
resp_router.sv
sigma_tile.sv
sigma_tile_props.sv
sigma_tile_tb.sv

/* Makefile */
TOOL    := verilator
FLAGS   := --binary --timing --assert -Wno-fatal
TOP     := sigma_tile_tb
FLIST   := sigma_tile.f
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
